//--- Bender.yml
package:
  name: io_unit

sources:
  - include_dirs:
      - .
    files:
      - io_pkg.sv
      - uart_if.sv
      - uart_rx.sv
      - uart_tx.sv
      - io_sequencer.sv
      - io_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_io_checker.sv
      - tb_io_unit.sv

//--- io_params.svh
`ifndef IO_PARAMS_SVH
`define IO_PARAMS_SVH

// ==================================================
// serial line timing
// ==================================================
`define IO_CLKS_PER_BIT 8

// ==================================================
// field widths
// ==================================================
`define IO_DATA_BITS 8
`define IO_OPCODE_BITS 6

// start + data + stop
`define IO_FRAME_BITS (1 + `IO_DATA_BITS + 1)

`endif

//--- io_pkg.sv
`include "io_params.svh"

package io_pkg;

    // port-I/O subset of the top instruction bits
    typedef enum logic [`IO_OPCODE_BITS-1:0] {
        OP_INLL  = 6'b110000,
        OP_INLH  = 6'b110001,
        OP_INUL  = 6'b110010,
        OP_INUH  = 6'b110011,
        OP_OUTLL = 6'b110100
    } io_opcode_t;

    // interlock sequencing
    typedef enum logic [2:0] {
        SEQ_RUN,
        SEQ_PRE_READ,
        SEQ_READ,
        SEQ_PRE_WRITE,
        SEQ_WRITE
    } io_seq_state_t;

endpackage

//--- io_sequencer.sv
`include "io_params.svh"

module io_sequencer (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     op_valid,
    input  io_pkg::io_opcode_t       op_code,
    input  logic [`IO_DATA_BITS-1:0] op_wdata,
    output logic                     interlock,
    output logic [`IO_DATA_BITS-1:0] rdata,
    output logic                     rdata_valid,
    uart_rd_if.seq                   rd,
    uart_wr_if.seq                   wr
);

    io_pkg::io_seq_state_t state;

    logic is_read;
    logic is_write;
    logic accept_rd;
    logic accept_wr;

    // ==================================================
    // opcode decode
    // ==================================================
    assign is_read  = (op_code == io_pkg::OP_INLL) || (op_code == io_pkg::OP_INLH) ||
                      (op_code == io_pkg::OP_INUL) || (op_code == io_pkg::OP_INUH);
    assign is_write = (op_code == io_pkg::OP_OUTLL);

    // ops only taken while the pipeline runs
    assign accept_rd = op_valid && is_read  && (state == io_pkg::SEQ_RUN);
    assign accept_wr = op_valid && is_write && (state == io_pkg::SEQ_RUN);

    // ==================================================
    // interlock fsm
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= io_pkg::SEQ_RUN;
            interlock   <= 1'b0;
            rdata_valid <= 1'b0;
            rd.ren      <= 1'b0;
            wr.wen      <= 1'b0;
        end else begin
            rd.ren      <= 1'b0;
            wr.wen      <= 1'b0;
            rdata_valid <= 1'b0;
            case (state)
                io_pkg::SEQ_RUN: begin
                    if (accept_rd) begin
                        interlock <= 1'b1;
                        state     <= io_pkg::SEQ_PRE_READ;
                    end else if (accept_wr) begin
                        interlock <= 1'b1;
                        state     <= io_pkg::SEQ_PRE_WRITE;
                    end
                end
                io_pkg::SEQ_PRE_READ: begin
                    if (!rd.rbusy) begin
                        rd.ren <= 1'b1;
                        state  <= io_pkg::SEQ_READ;
                    end
                end
                io_pkg::SEQ_READ: begin
                    if (rd.rdone) begin
                        rdata_valid <= 1'b1;
                        interlock   <= 1'b0;
                        state       <= io_pkg::SEQ_RUN;
                    end
                end
                io_pkg::SEQ_PRE_WRITE: begin
                    if (!wr.wbusy) begin
                        wr.wen <= 1'b1;
                        state  <= io_pkg::SEQ_WRITE;
                    end
                end
                io_pkg::SEQ_WRITE: begin
                    if (wr.wdone) begin
                        interlock <= 1'b0;
                        state     <= io_pkg::SEQ_RUN;
                    end
                end
                default: state <= io_pkg::SEQ_RUN;
            endcase
        end
    end

    // byte latches
    always_ff @(posedge clk) begin
        if (accept_wr) begin
            wr.wdata <= op_wdata;
        end
        if (state == io_pkg::SEQ_READ && rd.rdone) begin
            rdata <= rd.rdata;
        end
    end

endmodule

//--- io_unit.f
+incdir+.
io_pkg.sv
uart_if.sv
uart_rx.sv
uart_tx.sv
io_sequencer.sv
io_unit.sv
tb_io_checker.sv
tb_io_unit.sv

//--- io_unit.sv
`include "io_params.svh"

module io_unit (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     op_valid,
    input  io_pkg::io_opcode_t       op_code,
    input  logic [`IO_DATA_BITS-1:0] op_wdata,
    output logic                     interlock,
    output logic [`IO_DATA_BITS-1:0] rdata,
    output logic                     rdata_valid,
    input  logic                     rx,
    output logic                     tx
);

    uart_rd_if rd_bus ();
    uart_wr_if wr_bus ();

    // ==================================================
    // sequencing
    // ==================================================
    io_sequencer seq0 (
        .clk         (clk),
        .rstn        (rstn),
        .op_valid    (op_valid),
        .op_code     (op_code),
        .op_wdata    (op_wdata),
        .interlock   (interlock),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .rd          (rd_bus.seq),
        .wr          (wr_bus.seq)
    );

    // ==================================================
    // serial line
    // ==================================================
    uart_rx rx0 (
        .clk  (clk),
        .rstn (rstn),
        .rx   (rx),
        .rd   (rd_bus.uart)
    );

    uart_tx tx0 (
        .clk  (clk),
        .rstn (rstn),
        .tx   (tx),
        .wr   (wr_bus.uart)
    );

endmodule

//--- tb_io_checker.sv
`include "io_params.svh"

module tb_io_checker (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     interlock,
    input  logic [`IO_DATA_BITS-1:0] rdata,
    input  logic                     rdata_valid,
    input  logic                     tx,
    input  io_pkg::io_seq_state_t    seq_state,
    input  logic                     test_start,
    input  logic                     test_end,
    input  logic [1:0]               test_kind,
    input  logic [`IO_DATA_BITS-1:0] test_byte,
    input  logic                     report,
    output int                       errors
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [1:0] KIND_READ   = 2'd0;
    localparam logic [1:0] KIND_WRITE  = 2'd1;
    localparam logic [1:0] KIND_IGNORE = 2'd2;

    int                       tests = 0;
    int                       failed = 0;
    int                       test_errs = 0;
    int                       frame_count = 0;
    int                       frames_at_start = 0;
    int                       rv_count = 0;
    logic                     open = 1'b0;
    logic                     idle_bad = 1'b0;
    logic                     rv_prev = 1'b0;
    logic                     il_seen = 1'b0;
    logic                     tx_low_seen = 1'b0;
    logic                     frame_bad;
    logic                     frame_il_low;
    logic [`IO_DATA_BITS-1:0] frame_byte;
    logic [`IO_DATA_BITS-1:0] rv_data;

    initial begin
        errors = 0;
    end

    task automatic log_error(input string msg);
        $display("%s", msg);
        errors++;
        test_errs++;
    endtask

    function automatic string kind_name(input logic [1:0] kind);
        case (kind)
            KIND_READ:  return "read";
            KIND_WRITE: return "write";
            default:    return "ignored";
        endcase
    endfunction

    // ==================================================
    // tx frame decode at mid-bit
    // ==================================================
    initial begin : tx_decode
        int i;
        forever begin
            @(negedge clk);
            if (rstn === 1'b1 && tx === 1'b0) begin
                frame_bad    = 1'b0;
                frame_il_low = 1'b0;
                repeat (`IO_CLKS_PER_BIT / 2) @(negedge clk);
                frame_bad = (tx !== 1'b0);
                for (i = 0; i <= `IO_DATA_BITS; i++) begin
                    repeat (`IO_CLKS_PER_BIT) @(negedge clk);
                    if (i < `IO_DATA_BITS) begin
                        frame_byte[i] = tx;
                    end else if (tx !== 1'b1) begin
                        frame_bad = 1'b1;
                    end
                    if (interlock !== 1'b1) begin
                        frame_il_low = 1'b1;
                    end
                end
                frame_count++;
            end
        end
    end

    // per-test verdict
    task automatic finish_test();
        int frames;
        frames = frame_count - frames_at_start;
        if (test_kind != KIND_WRITE && tx_low_seen) begin
            log_error("tx left idle outside a write");
        end
        if (test_kind == KIND_READ && rv_count != 1) begin
            log_error($sformatf("saw %0d rdata_valid pulses, expected one", rv_count));
        end else if (test_kind == KIND_READ && rv_data !== test_byte) begin
            log_error($sformatf("mismatch rdata: got %h expected %h", rv_data, test_byte));
        end else if (test_kind != KIND_READ && rv_count != 0) begin
            log_error("rdata_valid pulsed without an input op");
        end
        if (test_kind == KIND_WRITE && frames != 1) begin
            log_error($sformatf("saw %0d tx frames, expected one", frames));
        end else if (test_kind == KIND_WRITE) begin
            if (frame_byte !== test_byte) begin
                log_error($sformatf("mismatch tx: got %h expected %h", frame_byte, test_byte));
            end
            if (frame_bad) begin
                log_error("tx frame has a bad start or stop bit");
            end
            if (frame_il_low) begin
                log_error("interlock dropped while the tx frame was on the line");
            end
        end
        if (test_kind == KIND_IGNORE && il_seen) begin
            log_error("interlock was raised for a non-I/O opcode");
        end else if (test_kind != KIND_IGNORE && !il_seen) begin
            log_error("interlock never rose for an I/O opcode");
        end
        tests++;
        if (test_errs != 0) begin
            failed++;
        end
        $display("test %0d %s %h: %s", tests, kind_name(test_kind), test_byte,
                 (test_errs == 0) ? "ok" : "failed");
        open     = 1'b0;
        idle_bad = 1'b0;
    endtask

    always @(negedge clk) begin
        if (rstn === 1'b1) begin
            if (test_start) begin
                open            = 1'b1;
                test_errs       = 0;
                rv_count        = 0;
                rv_prev         = 1'b0;
                il_seen         = 1'b0;
                tx_low_seen     = 1'b0;
                frames_at_start = frame_count;
            end
            // between tests and right after reset the unit must sit idle
            if (!open && !idle_bad &&
                (interlock !== 1'b0 || rdata_valid !== 1'b0 || tx !== 1'b1)) begin
                idle_bad = 1'b1;
                log_error("DUT is not idle outside a test");
            end
            if (open) begin
                if (rv_prev && interlock !== 1'b0) begin
                    log_error($sformatf("interlock still high after rdata_valid, state %s",
                                        seq_state.name()));
                end
                rv_prev = rdata_valid;
                if (rdata_valid === 1'b1) begin
                    rv_count++;
                    rv_data = rdata;
                end
                il_seen     = il_seen | interlock;
                tx_low_seen = tx_low_seen | !tx;
            end
            if (test_end) begin
                finish_test();
            end
            if (report) begin
                $display("tests %0d, passed %0d, failed %0d, errors %0d",
                         tests, tests - failed, failed, errors);
            end
        end
    end

endmodule

//--- tb_io_unit.sv
`include "io_params.svh"

module tb_io_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [1:0] KIND_READ   = 2'd0;
    localparam logic [1:0] KIND_WRITE  = 2'd1;
    localparam logic [1:0] KIND_IGNORE = 2'd2;
    localparam int N_TESTS     = 16;
    localparam int RST_CYCLES  = 8;
    localparam int MAX_CYCLES  =
        N_TESTS * (`IO_FRAME_BITS * `IO_CLKS_PER_BIT + 40) + RST_CYCLES;

    logic                     clk;
    logic                     rstn;
    logic                     op_valid;
    io_pkg::io_opcode_t       op_code;
    logic [`IO_DATA_BITS-1:0] op_wdata;
    logic                     interlock;
    logic [`IO_DATA_BITS-1:0] rdata;
    logic                     rdata_valid;
    logic                     rx;
    logic                     tx;
    logic                     test_start;
    logic                     test_end;
    logic                     report;
    logic [1:0]               test_kind;
    logic [`IO_DATA_BITS-1:0] test_byte;
    int                       errors;
    int                       cycle_cnt;
    int                       seed;

    // stimulus table
    logic [`IO_OPCODE_BITS-1:0] tbl_op   [N_TESTS];
    logic [`IO_DATA_BITS-1:0]   tbl_data [N_TESTS];
    logic [1:0]                 tbl_kind [N_TESTS];
    logic                       tbl_poke [N_TESTS];

    io_unit dut0 (.*);

    tb_io_checker chk0 (.seq_state(dut0.seq0.state), .*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    task automatic set_entry(input int idx, input logic [`IO_OPCODE_BITS-1:0] op,
                             input logic [`IO_DATA_BITS-1:0] data, input logic [1:0] kind,
                             input logic poke);
        tbl_op[idx]   = op;
        tbl_data[idx] = data;
        tbl_kind[idx] = kind;
        tbl_poke[idx] = poke;
    endtask

    // a poke adds a second op with the inverted byte on the first stalled cycle
    task automatic issue_op(input logic [`IO_OPCODE_BITS-1:0] op,
                            input logic [`IO_DATA_BITS-1:0] data,
                            input logic poke);
        @(posedge clk);
        op_valid <= 1'b1;
        op_code  <= io_pkg::io_opcode_t'(op);
        op_wdata <= data;
        @(posedge clk);
        if (poke) begin
            op_wdata <= ~data;
            @(posedge clk);
        end
        op_valid <= 1'b0;
    endtask

    task automatic wait_interlock(input logic level);
        @(negedge clk);
        while (interlock !== level) begin
            @(negedge clk);
        end
    endtask

    // start bit, lsb first, stop bit
    task automatic send_frame(input logic [`IO_DATA_BITS-1:0] data);
        int i;
        @(posedge clk);
        rx <= 1'b0;
        for (i = 0; i <= `IO_DATA_BITS; i++) begin
            repeat (`IO_CLKS_PER_BIT) @(posedge clk);
            rx <= (i < `IO_DATA_BITS) ? data[i] : 1'b1;
        end
        repeat (`IO_CLKS_PER_BIT) @(posedge clk);
    endtask

    // ==================================================
    // one table entry
    // ==================================================
    task automatic run_entry(input int idx);
        @(posedge clk);
        test_kind  <= tbl_kind[idx];
        test_byte  <= tbl_data[idx];
        test_start <= 1'b1;
        @(posedge clk);
        test_start <= 1'b0;
        issue_op(tbl_op[idx], tbl_data[idx], tbl_poke[idx]);
        if (tbl_kind[idx] == KIND_IGNORE) begin
            repeat (20) @(posedge clk);
        end else begin
            wait_interlock(1'b1);
            if (tbl_kind[idx] == KIND_READ) begin
                send_frame(tbl_data[idx]);
            end
            wait_interlock(1'b0);
        end
        @(posedge clk);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    initial begin : stimulus
        int          i;
        logic [31:0] r;
        seed       = 32'h10b6d56a;
        rstn       = 1'b0;
        op_valid   = 1'b0;
        op_code    = io_pkg::OP_INLL;
        op_wdata   = '0;
        rx         = 1'b1;
        test_start = 1'b0;
        test_end   = 1'b0;
        report     = 1'b0;
        test_kind  = '0;
        test_byte  = '0;
        set_entry(0, 6'h00, 8'h00, KIND_IGNORE, 1'b0);
        set_entry(1, io_pkg::OP_OUTLL, 8'ha5, KIND_WRITE, 1'b0);
        set_entry(2, io_pkg::OP_INLL, 8'h3c, KIND_READ, 1'b0);
        set_entry(3, io_pkg::OP_INLH, 8'hc3, KIND_READ, 1'b0);
        set_entry(4, io_pkg::OP_INUL, 8'h5a, KIND_READ, 1'b0);
        set_entry(5, io_pkg::OP_INUH, 8'h81, KIND_READ, 1'b0);
        // one code past the output op
        set_entry(6, 6'b110101, 8'hff, KIND_IGNORE, 1'b0);
        set_entry(7, io_pkg::OP_OUTLL, 8'h96, KIND_WRITE, 1'b1);
        for (i = 8; i < N_TESTS; i++) begin
            r = $random(seed);
            if (r[8]) begin
                set_entry(i, io_pkg::OP_OUTLL, r[7:0], KIND_WRITE, 1'b0);
            end else begin
                set_entry(i, io_pkg::OP_INLL | r[10:9], r[7:0], KIND_READ, 1'b0);
            end
        end
        repeat (RST_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        repeat (4) @(posedge clk);
        for (i = 0; i < N_TESTS; i++) begin
            run_entry(i);
        end
        @(posedge clk);
        report <= 1'b1;
        @(posedge clk);
        report <= 1'b0;
        @(negedge clk);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- uart_if.sv
`include "io_params.svh"

// receive side handshake
interface uart_rd_if;
    logic                     ren;
    logic [`IO_DATA_BITS-1:0] rdata;
    logic                     rbusy;
    logic                     rdone;

    modport seq  (output ren, input  rdata, rbusy, rdone);
    modport uart (input  ren, output rdata, rbusy, rdone);
endinterface

// transmit side handshake
interface uart_wr_if;
    logic                     wen;
    logic [`IO_DATA_BITS-1:0] wdata;
    logic                     wbusy;
    logic                     wdone;

    modport seq  (output wen, wdata, input  wbusy, wdone);
    modport uart (input  wen, wdata, output wbusy, wdone);
endinterface

//--- uart_rx.sv
`include "io_params.svh"

module uart_rx (
    input  logic   clk,
    input  logic   rstn,
    input  logic   rx,
    uart_rd_if.uart rd
);

    localparam int CNT_W = $clog2(`IO_CLKS_PER_BIT);
    localparam int IDX_W = $clog2(`IO_FRAME_BITS);
    localparam int HALF  = `IO_CLKS_PER_BIT / 2;

    logic [1:0]               rx_sync;
    logic                     rx_s;
    logic                     armed;
    logic [CNT_W-1:0]         bit_cnt;
    logic [IDX_W-1:0]         bit_idx;
    logic [`IO_DATA_BITS-1:0] shreg;
    logic                     sample;
    logic                     last_bit;

    assign rx_s     = rx_sync[1];
    assign sample   = rd.rbusy && (bit_cnt == '0);
    assign last_bit = (bit_idx == IDX_W'(`IO_FRAME_BITS - 1));

    // ==================================================
    // frame control
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rx_sync  <= 2'b11;
            armed    <= 1'b0;
            rd.rbusy <= 1'b0;
            rd.rdone <= 1'b0;
            bit_cnt  <= '0;
            bit_idx  <= '0;
        end else begin
            rx_sync  <= {rx_sync[0], rx};
            rd.rdone <= 1'b0;
            if (!rd.rbusy) begin
                // first sample lands mid start bit
                if (!rx_s) begin
                    rd.rbusy <= 1'b1;
                    bit_cnt  <= CNT_W'(HALF - 1);
                    bit_idx  <= '0;
                end
            end else if (bit_cnt != '0) begin
                bit_cnt <= bit_cnt - 1'b1;
            end else begin
                bit_cnt <= CNT_W'(`IO_CLKS_PER_BIT - 1);
                if (bit_idx == '0 && rx_s) begin
                    // glitch rather than a real start bit
                    rd.rbusy <= 1'b0;
                end else if (last_bit) begin
                    rd.rbusy <= 1'b0;
                    if (rx_s && armed) begin
                        rd.rdone <= 1'b1;
                        armed    <= 1'b0;
                    end
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end
            if (rd.ren) begin
                armed <= 1'b1;
            end
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (sample && bit_idx != '0 && !last_bit) begin
            shreg <= {rx_s, shreg[`IO_DATA_BITS-1:1]};
        end
        if (sample && last_bit) begin
            rd.rdata <= shreg;
        end
    end

endmodule

//--- uart_tx.sv
`include "io_params.svh"

module uart_tx (
    input  logic   clk,
    input  logic   rstn,
    output logic   tx,
    uart_wr_if.uart wr
);

    localparam int CNT_W = $clog2(`IO_CLKS_PER_BIT);
    localparam int IDX_W = $clog2(`IO_FRAME_BITS);

    logic [CNT_W-1:0]       bit_cnt;
    logic [IDX_W-1:0]       bit_idx;
    // data bits then the stop bit
    logic [`IO_DATA_BITS:0] shreg;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tx       <= 1'b1;
            wr.wbusy <= 1'b0;
            wr.wdone <= 1'b0;
            bit_cnt  <= '0;
            bit_idx  <= '0;
        end else begin
            wr.wdone <= 1'b0;
            if (!wr.wbusy) begin
                if (wr.wen) begin
                    // start bit
                    tx       <= 1'b0;
                    wr.wbusy <= 1'b1;
                    bit_cnt  <= '0;
                    bit_idx  <= '0;
                end
            end else if (bit_cnt != CNT_W'(`IO_CLKS_PER_BIT - 1)) begin
                bit_cnt <= bit_cnt + 1'b1;
            end else begin
                bit_cnt <= '0;
                if (bit_idx == IDX_W'(`IO_FRAME_BITS - 1)) begin
                    wr.wbusy <= 1'b0;
                    wr.wdone <= 1'b1;
                    tx       <= 1'b1;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                    tx      <= shreg[0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!wr.wbusy && wr.wen) begin
            shreg <= {1'b1, wr.wdata};
        end else if (wr.wbusy && bit_cnt == CNT_W'(`IO_CLKS_PER_BIT - 1)) begin
            shreg <= shreg >> 1;
        end
    end

endmodule
